//--- uart_periph.f
uart_pkg.sv
uart_baud_gen.sv
uart_rx.sv
uart_tx.sv
uart_regs.sv
uart_periph.sv
tb_uart_periph.sv

//--- Bender.yml
package:
  name: uart_periph

sources:
  - uart_pkg.sv
  - uart_baud_gen.sv
  - uart_rx.sv
  - uart_tx.sv
  - uart_regs.sv
  - uart_periph.sv
  - target: test
    files:
      - tb_uart_periph.sv

//--- tb_uart_periph.sv
`default_nettype none

module tb_uart_periph
  import uart_pkg::*;
();

  localparam int DATA_BUS_WIDTH = 16;
  localparam int ADDR_BUS_WIDTH = 11;
  localparam int CLKS_PER_TICK  = 4;
  localparam int BIT_CLKS       = UART_OVERSAMPLE * CLKS_PER_TICK;
  localparam int FRAME_CLKS     = UART_FRAME_BITS * BIT_CLKS;
  localparam int N_LOOP         = 4;
  // one frame for the tx check, the loopback frames and one idle frame for the glitch test
  localparam int N_FRAMES       = N_LOOP + 2;
  localparam int WATCHDOG_CLKS  = N_FRAMES * FRAME_CLKS + 2000;

  logic                      i_clk;
  logic                      i_rst;
  logic                      i_cs;
  logic                      i_w_r;
  logic [ADDR_BUS_WIDTH-1:0] i_addr;
  logic [DATA_BUS_WIDTH-1:0] i_wdata;
  logic [DATA_BUS_WIDTH-1:0] o_rdata;
  logic                      i_rx;
  logic                      o_tx;
  logic                      loopback;
  logic                      rx_drive;
  logic [31:0]               lfsr_state;

  // serial line either comes back from the transmitter or is driven directly
  assign i_rx = loopback ? o_tx : rx_drive;

  uart_periph #(
    .DATA_BUS_WIDTH (DATA_BUS_WIDTH),
    .ADDR_BUS_WIDTH (ADDR_BUS_WIDTH),
    .CLKS_PER_TICK  (CLKS_PER_TICK)
  ) i_uart_periph (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_cs    (i_cs),
    .i_w_r   (i_w_r),
    .i_addr  (i_addr),
    .i_wdata (i_wdata),
    .o_rdata (o_rdata),
    .i_rx    (i_rx),
    .o_tx    (o_tx)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  initial begin
    repeat (WATCHDOG_CLKS) @(posedge i_clk);
    $display("watchdog expired, the run hung waiting for the DUT");
    stop_with_failure();
  end

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_bits(input int nbits, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < nbits; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // expected line levels of one frame, index 0 goes out first
  function automatic logic [UART_FRAME_BITS-1:0] frame_of(input logic [7:0] b);
    return {1'b1, b, 1'b0};
  endfunction

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check(input string name, input logic [DATA_BUS_WIDTH-1:0] expected,
                       input logic [DATA_BUS_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic bus_write(input int unsigned a, input logic [DATA_BUS_WIDTH-1:0] d);
    @(posedge i_clk);
    i_cs    <= 1'b1;
    i_w_r   <= 1'b1;
    i_addr  <= ADDR_BUS_WIDTH'(a);
    i_wdata <= d;
    @(posedge i_clk);
    i_cs    <= 1'b0;
    i_w_r   <= 1'b0;
  endtask

  task automatic bus_read(input int unsigned a, output logic [DATA_BUS_WIDTH-1:0] d);
    @(posedge i_clk);
    i_cs   <= 1'b1;
    i_w_r  <= 1'b0;
    i_addr <= ADDR_BUS_WIDTH'(a);
    @(posedge i_clk);
    i_cs   <= 1'b0;
    @(negedge i_clk);
    d = o_rdata;
  endtask

  task automatic wait_frame_start();
    int n;
    n = 0;
    while (o_tx !== 1'b0 && n < 16 * CLKS_PER_TICK) begin
      @(negedge i_clk);
      n++;
    end
    if (o_tx !== 1'b0) begin
      $display("transmitter did not start a frame after TX_START was set");
      stop_with_failure();
    end
  endtask

  initial begin
    logic [DATA_BUS_WIDTH-1:0]  rd;
    logic [DATA_BUS_WIDTH-1:0]  wr;
    logic [DATA_BUS_WIDTH-1:0]  last;
    logic [31:0]                rnd;
    logic [7:0]                 tx_byte;
    logic [UART_FRAME_BITS-1:0] frame;

    i_rst      = 1'b1;
    i_cs       = 1'b0;
    i_w_r      = 1'b0;
    i_addr     = '0;
    i_wdata    = '0;
    loopback   = 1'b0;
    rx_drive   = 1'b1;
    lfsr_state = 32'h217690de;
    repeat (8) @(posedge i_clk);
    i_rst <= 1'b0;

    for (int unsigned a = 0; a <= REG_RX_DONE; a++) begin
      bus_read(a, rd);
      check($sformatf("reset value of offset %0d", a), '0, rd);
    end
    check("idle line after reset", DATA_BUS_WIDTH'(1'b1), DATA_BUS_WIDTH'(o_tx));

    for (int unsigned a = 0; a <= REG_RX_DONE; a++) begin
      random_bits(DATA_BUS_WIDTH, rnd);
      wr = rnd[DATA_BUS_WIDTH-1:0];
      // keep the transmitter idle while registers are exercised
      if (a == REG_TX_START) begin
        wr[0] = 1'b0;
      end
      bus_write(a, wr);
      bus_read(a, rd);
      check($sformatf("readback of offset %0d", a), wr, rd);
      last = rd;
    end
    bus_read(5, rd);
    check("unmapped read at 5", last, rd);
    bus_read(2047, rd);
    check("unmapped read at 2047", last, rd);
    for (int unsigned a = 0; a <= REG_RX_DONE; a++) begin
      bus_write(a, '0);
    end

    random_bits(UART_NB_BITS, rnd);
    tx_byte = rnd[7:0];
    frame   = frame_of(tx_byte);
    bus_write(REG_TX_DATA, DATA_BUS_WIDTH'(tx_byte));
    bus_write(REG_TX_START, DATA_BUS_WIDTH'(1'b1));
    wait_frame_start();
    repeat (BIT_CLKS / 2) @(negedge i_clk);
    for (int i = 0; i < UART_FRAME_BITS; i++) begin
      if (i > 0) begin
        repeat (BIT_CLKS) @(negedge i_clk);
      end
      check($sformatf("tx frame bit %0d", i), DATA_BUS_WIDTH'(frame[i]), DATA_BUS_WIDTH'(o_tx));
    end
    repeat (BIT_CLKS / 2 + 8) @(negedge i_clk);
    bus_read(REG_TX_DONE, rd);
    check("TX_DONE after frame", DATA_BUS_WIDTH'(1'b1), rd);
    bus_read(REG_TX_START, rd);
    check("TX_START after frame", '0, rd);

    @(posedge i_clk);
    loopback <= 1'b1;
    for (int n = 0; n < N_LOOP; n++) begin
      random_bits(UART_NB_BITS, rnd);
      tx_byte = rnd[7:0];
      // each frame has to set the receive flag again on its own
      bus_write(REG_RX_DONE, '0);
      bus_write(REG_TX_DATA, DATA_BUS_WIDTH'(tx_byte));
      bus_write(REG_TX_START, DATA_BUS_WIDTH'(1'b1));
      wait_frame_start();
      // no bus access while the frame runs, a strobe in a bus cycle would be lost
      repeat (FRAME_CLKS + 8) @(negedge i_clk);
      bus_read(REG_RX_DATA, rd);
      check($sformatf("loopback RX_DATA, frame %0d", n), DATA_BUS_WIDTH'(tx_byte), rd);
      bus_read(REG_RX_DONE, rd);
      check($sformatf("loopback RX_DONE, frame %0d", n), DATA_BUS_WIDTH'(1'b1), rd);
    end
    bus_write(REG_RX_DONE, '0);
    bus_write(REG_TX_DONE, '0);
    bus_read(REG_RX_DONE, rd);
    check("RX_DONE cleared", '0, rd);
    bus_read(REG_TX_DONE, rd);
    check("TX_DONE cleared", '0, rd);

    @(posedge i_clk);
    loopback <= 1'b0;
    rx_drive <= 1'b0;
    repeat (4 * CLKS_PER_TICK) @(posedge i_clk);
    rx_drive <= 1'b1;
    repeat (FRAME_CLKS) @(negedge i_clk);
    bus_read(REG_RX_DONE, rd);
    check("RX_DONE after short start pulse", '0, rd);
    bus_read(REG_RX_DATA, rd);
    check("RX_DATA after short start pulse", DATA_BUS_WIDTH'(tx_byte), rd);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- uart_periph.sv
`default_nettype none

module uart_periph import uart_pkg::*; #(
  parameter int DATA_BUS_WIDTH = 16,
  parameter int ADDR_BUS_WIDTH = 11,
  parameter int CLKS_PER_TICK  = 4
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_cs,
  input  logic                      i_w_r,
  input  logic [ADDR_BUS_WIDTH-1:0] i_addr,
  input  logic [DATA_BUS_WIDTH-1:0] i_wdata,
  output logic [DATA_BUS_WIDTH-1:0] o_rdata,
  input  logic                      i_rx,
  output logic                      o_tx
);

  logic                    tick;
  logic [UART_NB_BITS-1:0] rx_data;
  logic                    rx_done;
  logic [UART_NB_BITS-1:0] tx_data;
  logic                    tx_start;
  logic                    tx_done;

  uart_baud_gen #(
    .CLKS_PER_TICK (CLKS_PER_TICK)
  ) u_baud_gen (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .o_tick (tick)
  );

  uart_rx u_rx (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_tick (tick),
    .i_rx   (i_rx),
    .o_data (rx_data),
    .o_done (rx_done)
  );

  uart_tx u_tx (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_tick  (tick),
    .i_start (tx_start),
    .i_data  (tx_data),
    .o_tx    (o_tx),
    .o_done  (tx_done)
  );

  uart_regs #(
    .DATA_BUS_WIDTH (DATA_BUS_WIDTH),
    .ADDR_BUS_WIDTH (ADDR_BUS_WIDTH)
  ) u_regs (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_cs       (i_cs),
    .i_w_r      (i_w_r),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .o_rdata    (o_rdata),
    .i_rx_data  (rx_data),
    .i_rx_done  (rx_done),
    .i_tx_done  (tx_done),
    .o_tx_data  (tx_data),
    .o_tx_start (tx_start)
  );

endmodule

`default_nettype wire

//--- uart_regs.sv
`default_nettype none

module uart_regs import uart_pkg::*; #(
  parameter int DATA_BUS_WIDTH = 16,
  parameter int ADDR_BUS_WIDTH = 11
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_cs,
  input  logic                      i_w_r,
  input  logic [ADDR_BUS_WIDTH-1:0] i_addr,
  input  logic [DATA_BUS_WIDTH-1:0] i_wdata,
  output logic [DATA_BUS_WIDTH-1:0] o_rdata,
  input  logic [UART_NB_BITS-1:0]   i_rx_data,
  input  logic                      i_rx_done,
  input  logic                      i_tx_done,
  output logic [UART_NB_BITS-1:0]   o_tx_data,
  output logic                      o_tx_start
);

  logic [DATA_BUS_WIDTH-1:0] tx_data_q;
  logic [DATA_BUS_WIDTH-1:0] rx_data_q;
  uart_status_u              tx_done_q;
  uart_status_u              tx_start_q;
  uart_status_u              rx_done_q;
  logic                      wr_en;
  logic                      rd_en;

  assign wr_en = i_cs && i_w_r;
  assign rd_en = i_cs && !i_w_r;

  // any bus access claims the cycle, a strobe from rx or tx in that cycle is lost
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      tx_data_q  <= '0;
      rx_data_q  <= '0;
      tx_done_q  <= '0;
      tx_start_q <= '0;
      rx_done_q  <= '0;
      o_rdata    <= '0;
    end else if (wr_en) begin
      case (i_addr)
        REG_TX_DATA:  tx_data_q      <= i_wdata;
        REG_TX_DONE:  tx_done_q.raw  <= i_wdata;
        REG_TX_START: tx_start_q.raw <= i_wdata;
        REG_RX_DATA:  rx_data_q      <= i_wdata;
        REG_RX_DONE:  rx_done_q.raw  <= i_wdata;
        default: ;
      endcase
    end else if (rd_en) begin
      // unmapped reads keep the last value on the bus
      case (i_addr)
        REG_TX_DATA:  o_rdata <= tx_data_q;
        REG_TX_DONE:  o_rdata <= tx_done_q.raw;
        REG_TX_START: o_rdata <= tx_start_q.raw;
        REG_RX_DATA:  o_rdata <= rx_data_q;
        REG_RX_DONE:  o_rdata <= rx_done_q.raw;
        default: ;
      endcase
    end else begin
      if (i_rx_done) begin
        rx_data_q       <= DATA_BUS_WIDTH'(i_rx_data);
        rx_done_q.flags <= '{reserved: '0, flag: 1'b1};
      end
      if (i_tx_done) begin
        tx_done_q.flags  <= '{reserved: '0, flag: 1'b1};
        tx_start_q.flags <= '{reserved: '0, flag: 1'b0};
      end
    end
  end

  assign o_tx_data  = tx_data_q[UART_NB_BITS-1:0];
  assign o_tx_start = tx_start_q.flags.flag;

  a_bus_fits_byte : assert property (
    @(posedge i_clk) DATA_BUS_WIDTH >= UART_NB_BITS
  );

  // the status view in the package is fixed, so the bus has to match it
  a_status_width : assert property (
    @(posedge i_clk) DATA_BUS_WIDTH == $bits(uart_status_u)
  );

endmodule

`default_nettype wire

//--- uart_tx.sv
`default_nettype none

module uart_tx import uart_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_tick,
  input  logic                    i_start,
  input  logic [UART_NB_BITS-1:0] i_data,
  output logic                    o_tx,
  output logic                    o_done
);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  localparam int TICK_W = $clog2(UART_OVERSAMPLE);
  localparam int BIT_W  = $clog2(UART_FRAME_BITS);

  localparam logic [TICK_W-1:0] TICK_LAST     = TICK_W'(UART_OVERSAMPLE - 1);
  localparam logic [BIT_W-1:0]  LAST_DATA_IDX = BIT_W'(UART_FRAME_BITS - 2);

  logic [1:0]              state;
  logic [TICK_W-1:0]       tick_cnt;
  logic [BIT_W-1:0]        bit_idx;
  logic [UART_NB_BITS-1:0] shreg;
  logic                    bit_end;
  logic                    start_go;

  assign bit_end = i_tick && (tick_cnt == TICK_LAST);

  // starting on a tick keeps every bit exactly one bit time long.
  // the cycle of o_done is skipped, start has not dropped yet
  assign start_go = (state == S_IDLE) && i_start && i_tick && !o_done;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= S_IDLE;
      tick_cnt <= '0;
      bit_idx  <= '0;
      o_tx     <= 1'b1;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (state != S_IDLE && i_tick) begin
        tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (start_go) begin
            state    <= S_START;
            tick_cnt <= '0;
            bit_idx  <= '0;
            o_tx     <= 1'b0;
          end
        end
        S_START: begin
          if (bit_end) begin
            state   <= S_DATA;
            bit_idx <= bit_idx + 1'b1;
            o_tx    <= shreg[0];
          end
        end
        S_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == LAST_DATA_IDX) begin
              state <= S_STOP;
              o_tx  <= 1'b1;
            end else begin
              o_tx <= shreg[0];
            end
          end
        end
        default: begin
          if (bit_end) begin
            state  <= S_IDLE;
            o_done <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (start_go) begin
      shreg <= i_data;
    end else if (bit_end && (state == S_START || state == S_DATA)) begin
      shreg <= shreg >> 1;
    end
  end

  a_idle_high : assert property (
    @(posedge i_clk) disable iff (i_rst) (state == S_IDLE) |-> o_tx
  );

endmodule

`default_nettype wire

//--- uart_rx.sv
`default_nettype none

module uart_rx import uart_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_tick,
  input  logic                    i_rx,
  output logic [UART_NB_BITS-1:0] o_data,
  output logic                    o_done
);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  localparam int TICK_W = $clog2(UART_OVERSAMPLE);
  localparam int BIT_W  = $clog2(UART_NB_BITS);

  localparam logic [TICK_W-1:0] TICK_MID  = TICK_W'(UART_OVERSAMPLE / 2 - 1);
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(UART_OVERSAMPLE - 1);
  localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(UART_NB_BITS - 1);

  logic                    rx_meta;
  logic                    rx_sync;
  logic [1:0]              state;
  logic [TICK_W-1:0]       tick_cnt;
  logic [BIT_W-1:0]        bit_cnt;
  logic [UART_NB_BITS-1:0] shreg;
  logic                    sample;

  // the line idles high, so the synchronizer resets to 1 to avoid a false start
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
    end
  end

  // centre of a data bit, one full bit time after the previous centre
  assign sample = (state == S_DATA) && i_tick && (tick_cnt == TICK_LAST);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= S_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          tick_cnt <= '0;
          if (!rx_sync) begin
            state <= S_START;
          end
        end
        S_START: begin
          if (i_tick) begin
            if (tick_cnt == TICK_MID) begin
              // a glitch shorter than half a bit is dropped here
              tick_cnt <= '0;
              bit_cnt  <= '0;
              state    <= rx_sync ? S_IDLE : S_DATA;
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end
        S_DATA: begin
          if (i_tick) begin
            if (tick_cnt == TICK_LAST) begin
              tick_cnt <= '0;
              if (bit_cnt == BIT_LAST) begin
                state <= S_STOP;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end
        default: begin
          if (i_tick) begin
            if (tick_cnt == TICK_LAST) begin
              state  <= S_IDLE;
              o_done <= rx_sync;
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // first bit in ends up in bit 0
  always_ff @(posedge i_clk) begin
    if (sample) begin
      shreg <= {rx_sync, shreg[UART_NB_BITS-1:1]};
    end
  end

  assign o_data = shreg;

  a_done_pulse : assert property (
    @(posedge i_clk) disable iff (i_rst) o_done |=> !o_done
  );

endmodule

`default_nettype wire

//--- uart_baud_gen.sv
`default_nettype none

module uart_baud_gen #(
  parameter int CLKS_PER_TICK = 4
) (
  input  logic i_clk,
  input  logic i_rst,
  output logic o_tick
);

  localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_TICK - 1);

  logic [CNT_W-1:0] cnt;

  // tick is registered so it comes out clean, one clock wide
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt    <= '0;
      o_tick <= 1'b0;
    end else if (cnt == CNT_LAST) begin
      cnt    <= '0;
      o_tick <= 1'b1;
    end else begin
      cnt    <= cnt + 1'b1;
      o_tick <= 1'b0;
    end
  end

  generate
    if (CLKS_PER_TICK > 1) begin : g_tick_chk
      a_tick_single : assert property (
        @(posedge i_clk) disable iff (i_rst) o_tick |=> !o_tick
      );
    end
  endgenerate

endmodule

`default_nettype wire

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

  // frame format is 8N1, sent and received least significant bit first
  localparam int UART_NB_BITS    = 8;
  localparam int UART_OVERSAMPLE = 16;

  // start bit, data bits and one stop bit
  localparam int UART_FRAME_BITS = UART_NB_BITS + 2;

  // word offsets from the peripheral base address
  localparam int unsigned REG_TX_DATA  = 0;
  localparam int unsigned REG_TX_DONE  = 1;
  localparam int unsigned REG_TX_START = 2;
  localparam int unsigned REG_RX_DATA  = 3;
  localparam int unsigned REG_RX_DONE  = 4;

  localparam int UART_STATUS_WIDTH = 16;

  // status word shared by TX_DONE, TX_START and RX_DONE.
  // hardware sets the flag, the bus sees the whole word
  typedef union packed {
    logic [UART_STATUS_WIDTH-1:0] raw;
    struct packed {
      logic [UART_STATUS_WIDTH-2:0] reserved;
      logic                         flag;
    } flags;
  } uart_status_u;

endpackage

`default_nettype wire
